/* Bender.yml */
package:
  name: l1cache

sources:
  - cachePkg.sv
  - cacheTagStore.sv
  - cacheDataStore.sv
  - cacheController.sv
  - cacheStats.sv
  - l1Cache.sv
  - target: test
    files:
      - tbL1Cache.sv

/* cacheController.sv */
`timescale 1ns/1ps

module cacheController import cachePkg::*; #(
	parameter int IndexBits = 8,
	localparam int TagBits = AddrWidth - IndexBits - OffsetBits
) (
	input  logic                 clk,
	input  logic                 arstN,
	// Client side
	input  logic                 vmemRequest,
	input  logic                 vmemWe,
	input  addrT                 vmemAddress,
	input  wordT                 vmemWrData,
	input  logic                 opRequest,
	input  opCodeT               operation,
	output wordT                 vmemRdData,
	output logic                 vmemAck,
	// Memory side
	output logic                 memRequest,
	output logic                 memWe,
	output addrT                 memAddress,
	output wordT                 memWrData,
	input  wordT                 memRdData,
	input  logic                 memAck,
	// Store interface
	input  logic                 hit,
	input  wayT                  hitWay,
	input  wayT                  victimWay,
	input  wordT                 rdWord,
	output logic [IndexBits-1:0] index,
	output logic [TagBits-1:0]   tag,
	output logic                 tagWrEn,
	output wayT                  storeWay,
	output logic                 touchEn,
	output logic                 invalEn,
	output logic                 flushEn,
	output logic [1:0]           wordSel,
	output logic                 dataWrEn,
	output wordT                 dataWrWord,
	// Statistics pulses
	output logic                 evRead,
	output logic                 evWrite,
	output logic                 evHit,
	output logic                 evMiss,
	output logic                 evFill,
	output logic                 evInval
);

	ctrlStateT  stateQ;
	addrT       reqAddr;                           // Latched request
	logic       reqWe;
	logic       reqIsOp;                           // Operation, not a memory access
	opCodeT     reqOp;
	wordT       reqWrData;
	wayT        wayQ;                              // Way chosen at lookup
	logic [1:0] fillCnt;                           // Fill word number
	logic       isLookup;
	logic       isAccess;
	logic       fillPhase;

	////////////////////
	// Store control
	////////////////////
	assign isLookup  = (stateQ == sLookup);
	assign isAccess  = isLookup && !reqIsOp;    // Read or write lookup
	assign fillPhase = (stateQ inside {sFillReq, sFillWait, sFillDrop});

	assign index    = reqAddr[OffsetBits +: IndexBits];
	assign tag      = reqAddr[AddrWidth-1 -: TagBits];
	assign storeWay = isLookup ? (hit ? hitWay : victimWay) : wayQ;
	assign tagWrEn  = isAccess && !reqWe && !hit;            // Allocate on read miss only
	assign touchEn  = isAccess && (hit || !reqWe);           // Write miss leaves MRU alone
	assign invalEn  = isLookup && reqIsOp && (reqOp == opInvalLine);
	assign flushEn  = isLookup && reqIsOp && (reqOp == opFlushAll);

	assign wordSel    = fillPhase ? fillCnt : reqAddr[OffsetBits-1:2];
	assign dataWrEn   = (isAccess && reqWe && hit) || ((stateQ == sFillWait) && memAck);
	assign dataWrWord = fillPhase ? memRdData : reqWrData;

	// Event pulses, each state lasts one cycle when it fires
	assign evRead  = isAccess && !reqWe;
	assign evWrite = isAccess && reqWe;
	assign evHit   = isAccess && hit;
	assign evMiss  = isAccess && !hit;
	assign evInval = invalEn && hit;
	assign evFill  = (stateQ == sFillDrop) && !memAck && (fillCnt == 2'd3);

	////////////////////
	// FSM
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			stateQ     <= sIdle;
			vmemAck    <= 1'b0;
			memRequest <= 1'b0;
			memWe      <= 1'b0;
			fillCnt    <= '0;
		end
		else
		begin
			case (stateQ)
				sIdle:
					if (vmemRequest || opRequest)
						stateQ <= sLookup;
				sLookup:
				begin
					fillCnt <= '0;
					if (reqIsOp)
						stateQ <= sRespond;   // Operations end here
					else if (reqWe)
						stateQ <= sWrReq;     // Write-through always
					else if (hit)
						stateQ <= sRespond;
					else
						stateQ <= sFillReq;
				end
				sFillReq:
					if (!memAck)              // Previous exchange fully closed
					begin
						memRequest <= 1'b1;
						memWe      <= 1'b0;
						stateQ     <= sFillWait;
					end
				sFillWait:
					if (memAck)
					begin
						memRequest <= 1'b0;   // Word captured this cycle
						stateQ     <= sFillDrop;
					end
				sFillDrop:
					if (!memAck)
					begin
						if (fillCnt == 2'd3)
							stateQ <= sRespond;
						else
						begin
							fillCnt <= fillCnt + 2'd1;
							stateQ  <= sFillReq;
						end
					end
				sRespond:
				begin
					vmemAck <= 1'b1;
					stateQ  <= sAckHold;
				end
				sWrReq:
					if (!memAck)
					begin
						memRequest <= 1'b1;
						memWe      <= 1'b1;
						stateQ     <= sWrWait;
					end
				sWrWait:
					if (memAck)
					begin
						memRequest <= 1'b0;
						stateQ     <= sWrDrop;
					end
				sWrDrop:
					if (!memAck)
					begin
						memWe   <= 1'b0;
						vmemAck <= 1'b1;      // Ack straight after memory release
						stateQ  <= sAckHold;
					end
				sAckHold:
					if (!vmemRequest && !opRequest)
					begin
						vmemAck <= 1'b0;
						stateQ  <= sIdle;
					end
				default:
					stateQ <= sIdle;
			endcase
		end
	end

	// Request latch and bus payload
	always_ff @(posedge clk)
	begin
		if (stateQ == sIdle)
		begin
			reqAddr   <= vmemAddress;
			reqWe     <= vmemWe;
			reqWrData <= vmemWrData;
			reqOp     <= operation;
			reqIsOp   <= !vmemRequest;          // Memory access served first
		end
		if (isLookup)
			wayQ <= storeWay;
		if ((stateQ == sFillReq) && !memAck)
			memAddress <= {reqAddr[AddrWidth-1:OffsetBits], fillCnt, 2'b00};
		if ((stateQ == sWrReq) && !memAck)
		begin
			memAddress <= reqAddr;
			memWrData  <= reqWrData;
		end
		if ((stateQ == sRespond) && !reqIsOp)
			vmemRdData <= rdWord;                  // Held while vmemAck is high
	end

	////////////////////
	// Handshake checks
	////////////////////
	memReqRise: assert property (@(posedge clk) disable iff (!arstN)
		$rose(memRequest) |-> !$past(memAck))
		else $error("memRequest raised while memAck high");

	memAddrStable: assert property (@(posedge clk) disable iff (!arstN)
		(memRequest && $past(memRequest)) |-> $stable(memAddress))
		else $error("memAddress changed during exchange");

	ackRelease: assert property (@(posedge clk) disable iff (!arstN)
		$fell(vmemAck) |-> $past(!vmemRequest && !opRequest))
		else $error("vmemAck dropped with a request still high");

endmodule

/* cacheDataStore.sv */
`timescale 1ns/1ps

module cacheDataStore import cachePkg::*; #(
	parameter int IndexBits = 8
) (
	input  logic                 clk,
	input  logic [IndexBits-1:0] index,
	input  wayT                  way,
	input  logic [1:0]           wordSel,      // Word within the line
	input  logic                 wrEn,
	input  wordT                 wrWord,
	output wordT                 rdWord
);

	localparam int NumSets = 1 << IndexBits;

	// One line per set and way, addressed a word at a time
	wordT lineQ [NumSets][NumWays][LineWords];

	////////////////////
	// Word write
	////////////////////
	always_ff @(posedge clk)
	begin
		if (wrEn)
			lineQ[index][way][wordSel] <= wrWord;  // Visible next cycle
	end

	////////////////////
	// Word read
	////////////////////
	assign rdWord = lineQ[index][way][wordSel];  // Combinational select

endmodule

/* cachePkg.sv */
package cachePkg;

	////////////////////
	// Geometry
	////////////////////
	localparam int AddrWidth  = 32;                // Byte address
	localparam int WordWidth  = 32;                // Data word
	localparam int LineWords  = 4;                 // Words per line
	localparam int OffsetBits = 4;                 // 16 byte line
	localparam int NumWays    = 4;                 // Associativity

	////////////////////
	// Vector types
	////////////////////
	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [WordWidth-1:0] wordT;
	typedef logic [$clog2(NumWays)-1:0] wayT;     // Way number
	typedef logic [31:0] statT;                    // Statistics counter

	// Client operation codes, only these two do anything
	typedef enum logic [3:0] {
		opInvalLine = 4'd3,                        // Drop the addressed line
		opFlushAll  = 4'd4                         // Drop every line
	} opCodeT;

	// Controller states
	typedef enum logic [3:0] {
		sIdle,                                     // Wait for a request
		sLookup,                                   // Tag compare, store updates
		sFillReq,                                  // Raise fill read
		sFillWait,                                 // Wait memAck, capture word
		sFillDrop,                                 // Wait memAck low
		sRespond,                                  // Register read word
		sWrReq,                                    // Raise write-through
		sWrWait,                                   // Wait memAck
		sWrDrop,                                   // Wait memAck low
		sAckHold                                   // Hold vmemAck until release
	} ctrlStateT;

endpackage

/* cacheStats.sv */
`timescale 1ns/1ps

module cacheStats import cachePkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic evRead,
	input  logic evWrite,
	input  logic evHit,
	input  logic evMiss,
	input  logic evFill,
	input  logic evInval,
	output statT statReads,
	output statT statWrites,
	output statT statHits,
	output statT statMisses,
	output statT statFills,
	output statT statInvals
);

	localparam int NumCnt = 6;

	logic [NumCnt-1:0] evVec;                      // Pulses in counter order
	statT              cntQ [NumCnt];

	assign evVec = {evInval, evFill, evMiss, evHit, evWrite, evRead};

	////////////////////
	// Counter bank
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < NumCnt; i++)
				cntQ[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NumCnt; i++)
				if (evVec[i])
					cntQ[i] <= cntQ[i] + statT'(1);  // Wraps at full scale
		end
	end

	assign statReads  = cntQ[0];
	assign statWrites = cntQ[1];
	assign statHits   = cntQ[2];
	assign statMisses = cntQ[3];
	assign statFills  = cntQ[4];
	assign statInvals = cntQ[5];

endmodule

/* cacheTagStore.sv */
`timescale 1ns/1ps

module cacheTagStore import cachePkg::*; #(
	parameter int IndexBits = 8,
	localparam int TagBits = AddrWidth - IndexBits - OffsetBits
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic [IndexBits-1:0] index,
	input  logic [TagBits-1:0]   tag,
	input  logic                 wrEn,         // Install tag as valid
	input  wayT                  wrWay,        // Way for install and touch
	input  logic                 touchEn,      // Apply MRU rule to wrWay
	input  logic                 invalEn,      // Clear the hit way
	input  logic                 flushEn,      // Clear every set
	output logic                 hit,
	output wayT                  hitWay,
	output wayT                  victimWay
);

	localparam int NumSets = 1 << IndexBits;

	logic [NumWays-1:0] validQ [NumSets];
	logic [NumWays-1:0] mruQ [NumSets];
	logic [TagBits-1:0] tagQ [NumSets][NumWays];

	logic [NumWays-1:0] hitVec;                    // Per way match
	logic [NumWays-1:0] mruSet;                    // MRU bits with this way set
	logic [NumWays-1:0] mruNext;
	logic               dupTag;

	////////////////////
	// Lookup
	////////////////////
	always_comb
	begin
		for (int w = 0; w < NumWays; w++)
			hitVec[w] = validQ[index][w] && (tagQ[index][w] == tag);
	end

	assign hit = |hitVec;

	always_comb
	begin
		hitWay = '0;
		for (int w = NumWays - 1; w >= 0; w--)  // Lowest matching way wins
			if (hitVec[w])
				hitWay = wayT'(w);
	end

	// Lowest invalid way, else lowest way with MRU bit clear
	always_comb
	begin
		victimWay = '0;
		for (int w = NumWays - 1; w >= 0; w--)
			if (!mruQ[index][w])
				victimWay = wayT'(w);
		for (int w = NumWays - 1; w >= 0; w--)  // Invalid overrides MRU choice
			if (!validQ[index][w])
				victimWay = wayT'(w);
	end

	// Set this way's bit; if the set saturates keep only this way
	assign mruSet  = mruQ[index] | (NumWays'(1) << wrWay);
	assign mruNext = (&mruSet) ? (NumWays'(1) << wrWay) : mruSet;

	////////////////////
	// Update
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int s = 0; s < NumSets; s++)
			begin
				validQ[s] <= '0;
				mruQ[s]   <= '0;
			end
		end
		else if (flushEn)
		begin
			for (int s = 0; s < NumSets; s++)     // Whole cache in one cycle
			begin
				validQ[s] <= '0;
				mruQ[s]   <= '0;
			end
		end
		else
		begin
			if (wrEn)
				validQ[index][wrWay] <= 1'b1;
			if (invalEn && hit)                   // Miss on invalidate does nothing
				validQ[index][hitWay] <= 1'b0;
			if (touchEn)
				mruQ[index] <= mruNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			tagQ[index][wrWay] <= tag;
	end

	// A tag may live in only one valid way of a set
	always_comb
	begin
		dupTag = 1'b0;
		for (int i = 0; i < NumWays; i++)
			for (int j = i + 1; j < NumWays; j++)
				if (validQ[index][i] && validQ[index][j] && (tagQ[index][i] == tagQ[index][j]))
					dupTag = 1'b1;
	end

	noDupTag: assert property (@(posedge clk) disable iff (!arstN) !dupTag)
		else $error("Duplicate valid tag in set %0d", index);

endmodule

/* flist.f */
cachePkg.sv
cacheTagStore.sv
cacheDataStore.sv
cacheController.sv
cacheStats.sv
l1Cache.sv
tbL1Cache.sv

/* l1Cache.sv */
`timescale 1ns/1ps

module l1Cache import cachePkg::*; #(
	parameter int IndexBits = 8,
	localparam int TagBits = AddrWidth - IndexBits - OffsetBits
) (
	input  logic   clk,
	input  logic   arstN,
	input  logic   vmemRequest,                    // Client access
	input  logic   vmemWe,
	input  addrT   vmemAddress,
	input  wordT   vmemWrData,
	input  logic   opRequest,                      // Client operation
	input  opCodeT operation,
	output wordT   vmemRdData,
	output logic   vmemAck,
	output logic   memRequest,                     // Word memory port
	output logic   memWe,
	output addrT   memAddress,
	output wordT   memWrData,
	input  wordT   memRdData,
	input  logic   memAck,
	output statT   statReads,
	output statT   statWrites,
	output statT   statHits,
	output statT   statMisses,
	output statT   statFills,
	output statT   statInvals
);

	logic [IndexBits-1:0] index;
	logic [TagBits-1:0]   tag;
	logic                 tagWrEn;
	wayT                  storeWay;
	logic                 touchEn;
	logic                 invalEn;
	logic                 flushEn;
	logic                 hit;
	wayT                  hitWay;
	wayT                  victimWay;
	logic [1:0]           wordSel;
	logic                 dataWrEn;
	wordT                 dataWrWord;
	wordT                 rdWord;
	logic                 evRead;
	logic                 evWrite;
	logic                 evHit;
	logic                 evMiss;
	logic                 evFill;
	logic                 evInval;

	cacheController #(.IndexBits(IndexBits)) u_cacheController (
		.clk, .arstN,
		.vmemRequest, .vmemWe, .vmemAddress, .vmemWrData, .opRequest, .operation,
		.vmemRdData, .vmemAck,
		.memRequest, .memWe, .memAddress, .memWrData, .memRdData, .memAck,
		.hit, .hitWay, .victimWay, .rdWord,
		.index, .tag, .tagWrEn, .storeWay, .touchEn, .invalEn, .flushEn,
		.wordSel, .dataWrEn, .dataWrWord,
		.evRead, .evWrite, .evHit, .evMiss, .evFill, .evInval
	);

	////////////////////
	// Stores
	////////////////////
	cacheTagStore #(.IndexBits(IndexBits)) u_cacheTagStore (
		.clk, .arstN, .index, .tag,
		.wrEn(tagWrEn), .wrWay(storeWay), .touchEn, .invalEn, .flushEn,
		.hit, .hitWay, .victimWay
	);

	cacheDataStore #(.IndexBits(IndexBits)) u_cacheDataStore (
		.clk, .index, .way(storeWay), .wordSel,
		.wrEn(dataWrEn), .wrWord(dataWrWord), .rdWord
	);

	cacheStats u_cacheStats (
		.clk, .arstN,
		.evRead, .evWrite, .evHit, .evMiss, .evFill, .evInval,
		.statReads, .statWrites, .statHits, .statMisses, .statFills, .statInvals
	);

endmodule

/* tbL1Cache.sv */
`timescale 1ns/1ps

module tbL1Cache import cachePkg::*; ();

	localparam int TbIndexBits    = 4;
	localparam int TagBits        = AddrWidth - TbIndexBits - OffsetBits;
	localparam int NumSets        = 1 << TbIndexBits;
	localparam int AckLimit       = 200;       // Cycles allowed per ack edge
	localparam int WatchdogCycles = 6000;      // About 25 requests at up to 40 cycles each with margin

	logic clk, arstN;
	logic vmemRequest, vmemWe, opRequest, vmemAck;
	addrT vmemAddress;
	wordT vmemWrData, vmemRdData;
	opCodeT operation;
	logic memRequest, memWe, memAck;
	addrT memAddress;
	wordT memWrData, memRdData;
	statT statReads, statWrites, statHits, statMisses, statFills, statInvals;

	integer seed = 32'h63b8;
	int     errors = 0;
	int     checks = 0;

	wordT memMap [addrT];                      // Memory model contents
	wordT refMem [addrT];                      // Reference word map
	addrT logAddr [$];                         // Memory exchanges seen
	logic logWe [$];
	wordT logData [$];

	bit                 refValid [NumSets][NumWays];
	bit                 refMru [NumSets][NumWays];
	logic [TagBits-1:0] refTag [NumSets][NumWays];
	statT expReads = 0, expWrites = 0, expHits = 0, expMisses = 0, expFills = 0, expInvals = 0;

	l1Cache #(.IndexBits(TbIndexBits)) u_l1Cache (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Memory model
	////////////////////
	initial
	begin : memoryModel
		int waitCycles;
		forever
		begin
			@(posedge clk);
			#10;
			if (memRequest && !memAck)
			begin
				waitCycles = $unsigned($random(seed)) % 4;  // 0 to 3 cycles
				repeat (waitCycles)
				begin
					@(posedge clk);
					#10;
				end
				logAddr.push_back(memAddress);
				logWe.push_back(memWe);
				logData.push_back(memWrData);
				if (memWe)
					memMap[memAddress] = memWrData;
				else
					memRdData = memMap.exists(memAddress) ? memMap[memAddress]
						: memAddress ^ 32'hA5A5_0000;
				memAck = 1'b1;
				do
				begin
					@(posedge clk);
					#10;
				end while (memRequest);              // Release phase
				memAck = 1'b0;
			end
		end
	end

	// Reference model helpers
	function automatic int setOf(input addrT a);
		return a[OffsetBits +: TbIndexBits];
	endfunction

	function automatic logic [TagBits-1:0] tagOf(input addrT a);
		return a[AddrWidth-1 -: TagBits];
	endfunction

	function automatic wordT expWord(input addrT a);
		return refMem.exists(a) ? refMem[a] : a ^ 32'hA5A5_0000;
	endfunction

	function automatic int findWay(input addrT a);  // -1 on miss
		for (int w = 0; w < NumWays; w++)
			if (refValid[setOf(a)][w] && refTag[setOf(a)][w] == tagOf(a))
				return w;
		return -1;
	endfunction

	function automatic int pickVictim(input int s);
		for (int w = 0; w < NumWays; w++)
			if (!refValid[s][w])
				return w;
		for (int w = 0; w < NumWays; w++)
			if (!refMru[s][w])
				return w;
		return 0;
	endfunction

	function automatic void touchWay(input int s, input int w);
		bit full;
		refMru[s][w] = 1'b1;
		full = 1'b1;
		for (int k = 0; k < NumWays; k++)
			full &= refMru[s][k];
		if (full)                                // Saturated set keeps only this way
			for (int k = 0; k < NumWays; k++)
				refMru[s][k] = (k == w);
	endfunction

	function automatic addrT set5Addr(input logic [TagBits-1:0] t);
		return {t, 8'h50};                       // Word 0 of set 5
	endfunction

	////////////////////
	// Compare tasks
	////////////////////
	task automatic checkWord(input string name, input wordT got, input wordT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input addrT got, input addrT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkStat(input string name, input statT got, input statT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compareStats();
		checkStat("statReads", statReads, expReads);
		checkStat("statWrites", statWrites, expWrites);
		checkStat("statHits", statHits, expHits);
		checkStat("statMisses", statMisses, expMisses);
		checkStat("statFills", statFills, expFills);
		checkStat("statInvals", statInvals, expInvals);
	endtask

	// Entered and left at edge plus 10 ns
	task automatic waitAck(input logic level);
		int n;
		n = 0;
		while (vmemAck !== level && n < AckLimit)
		begin
			@(posedge clk);
			#10;
			n++;
		end
		if (vmemAck !== level)
		begin
			errors++;
			$display("%0t ns: vmemAck did not go to %b within %0d cycles", $time, level, AckLimit);
		end
	endtask

	task automatic clearLog();
		logAddr.delete();
		logWe.delete();
		logData.delete();
	endtask

	////////////////////
	// Client transactions
	////////////////////
	task automatic clientRead(input addrT addr);
		int   s;
		int   w;
		addrT base;
		s    = setOf(addr);
		w    = findWay(addr);
		base = {addr[AddrWidth-1:OffsetBits], 4'h0};
		clearLog();
		vmemAddress = addr;
		vmemWe      = 1'b0;
		vmemRequest = 1'b1;
		waitAck(1'b1);
		checkWord("vmemRdData", vmemRdData, expWord(addr));
		vmemRequest = 1'b0;
		waitAck(1'b0);
		if (w >= 0 && logAddr.size() != 0)
		begin
			errors++;
			$display("%0t ns: read hit at %h went to memory", $time, addr);
		end
		else if (w < 0 && logAddr.size() != LineWords)
		begin
			errors++;
			$display("%0t ns: read miss at %h made %0d memory exchanges instead of four",
				$time, addr, logAddr.size());
		end
		else
			for (int i = 0; i < logAddr.size(); i++)
			begin
				checkAddr("memAddress", logAddr[i], base + addrT'(4 * i));  // Line base up
				checkBit("memWe", logWe[i], 1'b0);
			end
		expReads++;
		if (w >= 0)
		begin
			expHits++;
			touchWay(s, w);
		end
		else
		begin
			w = pickVictim(s);                   // Install into the victim way
			refValid[s][w] = 1'b1;
			refTag[s][w]   = tagOf(addr);
			touchWay(s, w);
			expMisses++;
			expFills++;
		end
	endtask

	task automatic clientWrite(input addrT addr, input wordT data);
		int w;
		w = findWay(addr);
		clearLog();
		vmemAddress = addr;
		vmemWe      = 1'b1;
		vmemWrData  = data;
		vmemRequest = 1'b1;
		waitAck(1'b1);
		vmemRequest = 1'b0;
		vmemWe      = 1'b0;
		waitAck(1'b0);
		if (logAddr.size() != 1)
		begin
			errors++;
			$display("%0t ns: write to %h made %0d memory exchanges instead of one",
				$time, addr, logAddr.size());
		end
		else
		begin
			checkAddr("memAddress", logAddr[0], addr);
			checkBit("memWe", logWe[0], 1'b1);
			checkWord("memWrData", logData[0], data);
		end
		refMem[addr] = data;                     // Write-through without allocate
		expWrites++;
		if (w >= 0)
		begin
			expHits++;
			touchWay(setOf(addr), w);
		end
		else
			expMisses++;
	endtask

	task automatic clientOp(input opCodeT op, input addrT addr);
		int w;
		w = findWay(addr);
		clearLog();
		vmemAddress = addr;
		operation   = op;
		opRequest   = 1'b1;
		waitAck(1'b1);
		opRequest = 1'b0;
		waitAck(1'b0);
		if (logAddr.size() != 0)
		begin
			errors++;
			$display("%0t ns: operation %0d went to memory", $time, op);
		end
		if (op == opInvalLine && w >= 0)
		begin
			refValid[setOf(addr)][w] = 1'b0;     // MRU bits untouched
			expInvals++;
		end
		if (op == opFlushAll)
			for (int s = 0; s < NumSets; s++)
				for (int k = 0; k < NumWays; k++)
				begin
					refValid[s][k] = 1'b0;
					refMru[s][k]   = 1'b0;
				end
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic testReset();
		checkBit("vmemAck", vmemAck, 1'b0);
		checkBit("memRequest", memRequest, 1'b0);
		checkBit("memWe", memWe, 1'b0);
		compareStats();
	endtask

	task automatic testReadMiss();
		clientRead(32'h0000_1238);               // Miss fills from the line base
		for (int i = 0; i < LineWords; i++)
			clientRead(32'h0000_1230 + addrT'(4 * i));
	endtask

	task automatic testWrite();
		clientWrite(32'h0000_1234, 32'hDEAD_BEEF);  // Hit
		clientRead(32'h0000_1234);
		clientWrite(32'h0002_0040, 32'h1357_9BDF);  // Miss writes memory only
		clientRead(32'h0002_0040);
	endtask

	task automatic testReplace();
		logic [TagBits-1:0] evicted;
		for (int t = 0; t < 4; t++)
			clientRead(set5Addr(TagBits'(24'h100 + t)));  // Fill all four ways
		clientRead(set5Addr(24'h100));           // Touch ways 0 and 1
		clientRead(set5Addr(24'h101));
		evicted = refTag[5][pickVictim(5)];      // Tag the MRU rule drops next
		clientRead(set5Addr(24'h104));           // Fill into the victim way
		clientRead(set5Addr(24'h103));
		clientRead(set5Addr(evicted));           // Evicted tag must fill again
	endtask

	task automatic testInvalFlush();
		clientOp(opInvalLine, 32'h0000_1230);
		clientRead(32'h0000_1230);
		clientOp(opInvalLine, 32'h0009_9990);    // Not cached
		checkStat("statInvals", statInvals, expInvals);
		clientOp(opFlushAll, 32'h0000_0000);
		clientRead(32'h0000_1234);
		clientRead(set5Addr(24'h104));
		clientRead(32'h0002_0040);
	endtask

	initial
	begin
		arstN       = 1'b0;
		vmemRequest = 1'b0;
		vmemWe      = 1'b0;
		vmemAddress = '0;
		vmemWrData  = '0;
		opRequest   = 1'b0;
		operation   = opInvalLine;
		memRdData   = '0;
		memAck      = 1'b0;
		repeat (10) @(posedge clk);
		#10;
		arstN = 1'b1;
		testReset();
		testReadMiss();
		testWrite();
		testReplace();
		testInvalFlush();
		compareStats();                          // Final counts against the model
		$display("Run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding", WatchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule
